// File: hdl/sample_pkg.sv
/*
  ADC sample stream definitions
  - channel count and sample width
  - banking mode code and derived index widths
*/
`default_nettype none

package sample_pkg;

  // parallel adc channels, one memory bank per channel
  localparam int CHANNELS = 4;
  // bits per sample word
  localparam int DATA_WIDTH = 16;

  // banking mode code, active channels = 1 << mode
  localparam int MODE_WIDTH = 2;

  // index of one bank or one channel
  localparam int CHAN_SEL_WIDTH = $clog2(CHANNELS);
  // active channel count, 1 up to CHANNELS inclusive
  localparam int ACTIVE_WIDTH = $clog2(CHANNELS + 1);

endpackage

`default_nettype wire

// File: hdl/memory_pkg.sv
/*
  sample memory definitions
  - bank depth and address width
  - per-bank status word width
  - read pipeline latency
*/
`default_nettype none

package memory_pkg;

  // samples stored per bank
  localparam int BUFFER_DEPTH = 16;
  // bank address, also the sample count field of the status word
  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  // status word per bank, full bit on top of the address
  localparam int DEPTH_WIDTH = ADDR_WIDTH + 1;

  // register stages between the ram read and the read data port
  localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

// File: hdl/buffer_mem_if.sv
/*
  sample buffer memory ports
  - per-bank write port driven from the capture side
  - shared read address, advance strobe and read data
*/
`default_nettype none

interface buffer_mem_if
  import sample_pkg::*, memory_pkg::*;
  ();

  // write side, one enable and address per bank
  logic [CHANNELS-1:0]                 wr_en;
  logic [CHANNELS-1:0][ADDR_WIDTH-1:0] wr_addr;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0] wr_data;

  // read side, every bank read at the same address
  logic [ADDR_WIDTH-1:0]               rd_addr;
  // shifts the read pipeline by one stage
  logic                                rd_advance;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0] rd_data;

  modport writer (output wr_en, wr_addr, wr_data);
  modport reader (output rd_addr, rd_advance, input rd_data);
  modport memory (
    input  wr_en, wr_addr, wr_data, rd_addr, rd_advance,
    output rd_data
  );

endinterface

`default_nettype wire

// File: hdl/capture_control.sv
/*
  capture control
  - idle / trigger-wait / save / hold FSM
  - banking mode register, trigger gating
  - capture-active flag and capture done pulse
*/
`default_nettype none

module capture_control
  import sample_pkg::*;
(
  input  wire                     adc_clk,
  input  wire                     adc_reset,
  input  wire                     arm,
  input  wire  [MODE_WIDTH-1:0]   banking_mode,
  input  wire                     banking_mode_valid,
  input  wire                     capture_sw_reset,
  input  wire                     hw_start,
  input  wire                     hw_stop,
  input  wire                     capture_full,
  input  wire                     chain_fill,
  input  wire                     readout_done,
  output logic                    capture_active,
  output logic                    start_pulse,
  output logic [ACTIVE_WIDTH-1:0] active_channels,
  output logic                    clear,
  output logic                    capture_done
);

  enum logic [1:0] {IDLE, TRIGGER_WAIT, SAVE, HOLD} state;

  logic stop_pulse;
  // previous capture_full, for edge detect
  logic full_d;

  // triggers only count in their own state
  assign start_pulse = (state == TRIGGER_WAIT) && hw_start;
  assign stop_pulse  = (state == SAVE) && hw_stop;
  // addresses and full latches restart after sw reset or a finished readout
  assign clear = capture_sw_reset | readout_done;

  // banking mode, only taken while idle
  // modes beyond CHANNELS are dropped
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active_channels <= ACTIVE_WIDTH'(CHANNELS);
    end else if (banking_mode_valid && state == IDLE &&
                 banking_mode <= MODE_WIDTH'(CHAN_SEL_WIDTH)) begin
      active_channels <= ACTIVE_WIDTH'(1) << banking_mode;
    end
  end

  //////////////////////////////////////////////////
  // capture-active flag and done pulse
  //////////////////////////////////////////////////

  // set on start, dropped on stop or when the last bank of a chain fills
  always_ff @(posedge adc_clk) begin
    if (adc_reset || capture_sw_reset) begin
      capture_active <= 1'b0;
    end else if (start_pulse) begin
      capture_active <= 1'b1;
    end else if (stop_pulse || chain_fill) begin
      capture_active <= 1'b0;
    end
  end

  // one cycle after a stop or the rising edge of full
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      full_d       <= 1'b0;
      capture_done <= 1'b0;
    end else begin
      full_d       <= capture_full;
      capture_done <= ~capture_sw_reset & ((capture_full & ~full_d) | stop_pulse);
    end
  end

  //////////////////////////////////////////////////
  // capture FSM
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset || capture_sw_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (arm) begin
            state <= TRIGGER_WAIT;
          end
        end
        TRIGGER_WAIT: begin
          if (start_pulse) begin
            state <= SAVE;
          end
        end
        SAVE: begin
          // full or stop, data held until read out
          if (stop_pulse || capture_full) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (readout_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // chain_fill from the writer drops the flag before full moves us to hold
  a_active_in_save : assert property (
    @(posedge adc_clk) disable iff (adc_reset)
    capture_active |-> state == SAVE
  );

endmodule

`default_nettype wire

// File: hdl/bank_writer.sv
/*
  bank writer
  - channel data/valid mux per banking mode
  - valid mask chaining of spare banks
  - write addresses, full latches, write depth status
*/
`default_nettype none

module bank_writer
  import sample_pkg::*, memory_pkg::*;
(
  input  wire                                  adc_clk,
  input  wire                                  adc_reset,
  input  wire  [CHANNELS-1:0][DATA_WIDTH-1:0]  sample_data,
  input  wire  [CHANNELS-1:0]                  sample_valid,
  input  wire                                  capture_active,
  input  wire                                  start_pulse,
  input  wire  [ACTIVE_WIDTH-1:0]              active_channels,
  input  wire                                  clear,
  output logic                                 capture_full,
  output logic                                 chain_fill,
  output logic [CHANNELS-1:0][DEPTH_WIDTH-1:0] write_depth,
  buffer_mem_if.writer                         mem
);

  logic [CHANNELS-1:0][CHAN_SEL_WIDTH-1:0] src_chan;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0]     data_d;
  logic [CHANNELS-1:0]                     valid_d;
  logic [CHANNELS-1:0]                     write_enable;
  logic [CHANNELS-1:0][ADDR_WIDTH-1:0]     write_addr;
  logic [CHANNELS-1:0]                     bank_fill;
  logic [CHANNELS-1:0]                     full_latch;
  logic [CHANNELS-1:0]                     valid_mask;
  logic [CHANNELS-1:0]                     full_mask;

  //////////////////////////////////////////////////
  // per-bank decode
  //////////////////////////////////////////////////
  always_comb begin
    for (int b = 0; b < CHANNELS; b++) begin
      // bank b listens to channel b modulo the active count
      src_chan[b] = CHAN_SEL_WIDTH'(ACTIVE_WIDTH'(b) % active_channels);
      // last bank of each chain, i.e. the top active-count banks
      full_mask[b] = ACTIVE_WIDTH'(b) + active_channels >= ACTIVE_WIDTH'(CHANNELS);
      write_enable[b] = capture_active & valid_mask[b] & valid_d[src_chan[b]];
      // this write lands on the last address
      bank_fill[b] = write_enable[b] && write_addr[b] == ADDR_WIDTH'(BUFFER_DEPTH - 1);
      write_depth[b] = {full_latch[b], write_addr[b]};
    end
  end

  assign capture_full = |(full_mask & full_latch);
  assign chain_fill   = |(full_mask & bank_fill);

  //////////////////////////////////////////////////
  // input registers and write port
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    data_d <= sample_data;
    for (int b = 0; b < CHANNELS; b++) begin
      mem.wr_data[b] <= data_d[src_chan[b]];
    end
    // address delayed to line up with the muxed data
    mem.wr_addr <= write_addr;
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_d    <= '0;
      mem.wr_en  <= '0;
    end else begin
      valid_d    <= sample_valid;
      mem.wr_en  <= write_enable;
    end
  end

  // valid mask, reloaded on start with the first active banks
  // a filled bank hands over to the bank active_channels above it
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_mask <= '0;
    end else if (start_pulse) begin
      for (int b = 0; b < CHANNELS; b++) begin
        valid_mask[b] <= ACTIVE_WIDTH'(b) < active_channels;
      end
    end else begin
      for (int b = 0; b < CHANNELS; b++) begin
        if (bank_fill[b]) begin
          valid_mask[b] <= 1'b0;
          if (!full_mask[b]) begin
            valid_mask[CHAN_SEL_WIDTH'(ACTIVE_WIDTH'(b) + active_channels)] <= 1'b1;
          end
        end
      end
    end
  end

  // addresses wrap to zero after the last word, full bit keeps the count
  always_ff @(posedge adc_clk) begin
    if (adc_reset || clear) begin
      write_addr <= '0;
      full_latch <= '0;
    end else begin
      for (int b = 0; b < CHANNELS; b++) begin
        if (write_enable[b]) begin
          write_addr[b] <= write_addr[b] + 1'b1;
        end
        if (bank_fill[b]) begin
          full_latch[b] <= 1'b1;
        end
      end
    end
  end

  // mask handover must close a bank the cycle after it fills
  a_no_write_when_full : assert property (
    @(posedge adc_clk) disable iff (adc_reset)
    (write_enable & full_latch) == '0
  );

endmodule

`default_nettype wire

// File: hdl/sample_memory.sv
/*
  banked sample ram
  - one write port per bank
  - common read address with an advance-gated read pipeline
*/
`default_nettype none

module sample_memory
  import sample_pkg::*, memory_pkg::*;
(
  input wire           adc_clk,
  buffer_mem_if.memory mem
);

  logic [DATA_WIDTH-1:0] ram [CHANNELS][BUFFER_DEPTH];
  // stage 0 holds the raw ram read
  logic [READ_LATENCY-1:0][CHANNELS-1:0][DATA_WIDTH-1:0] rd_pipe;

  always_ff @(posedge adc_clk) begin
    for (int b = 0; b < CHANNELS; b++) begin
      if (mem.wr_en[b]) begin
        ram[b][mem.wr_addr[b]] <= mem.wr_data[b];
      end
    end
  end

  // whole pipe stalls together, so in-flight reads keep their order
  always_ff @(posedge adc_clk) begin
    if (mem.rd_advance) begin
      for (int b = 0; b < CHANNELS; b++) begin
        rd_pipe[0][b] <= ram[b][mem.rd_addr];
      end
      for (int s = 1; s < READ_LATENCY; s++) begin
        rd_pipe[s] <= rd_pipe[s-1];
      end
    end
  end

  assign mem.rd_data = rd_pipe[READ_LATENCY-1];

endmodule

`default_nettype wire

// File: hdl/readout_engine.sv
/*
  readout engine
  - idle / ready / active FSM and start pulse
  - address and bank sequencing over all banks
  - valid/last/bank pipeline and registered output mux
*/
`default_nettype none

module readout_engine
  import sample_pkg::*, memory_pkg::*;
(
  input  wire                   adc_clk,
  input  wire                   adc_reset,
  input  wire                   capture_done,
  input  wire                   readout_start,
  input  wire                   readout_ready,
  output logic                  readout_done,
  output logic [DATA_WIDTH-1:0] readout_data,
  output logic                  readout_valid,
  output logic                  readout_last,
  buffer_mem_if.reader          mem
);

  enum logic [1:0] {IDLE, READY, ACTIVE} state;

  logic                      start_pulse;
  // high while addresses are still being issued
  logic                      active;
  logic                      advance;
  logic                      step;
  logic                      addr_last;
  logic [ADDR_WIDTH-1:0]     rd_addr;
  logic [CHAN_SEL_WIDTH-1:0] bank_sel;
  logic [READ_LATENCY-1:0]   valid_pipe;
  logic [READ_LATENCY-1:0]   last_pipe;
  logic [READ_LATENCY-1:0][CHAN_SEL_WIDTH-1:0] bank_pipe;

  // everything moves unless the output holds a beat that is not taken
  assign advance   = readout_ready | ~readout_valid;
  assign step      = active & advance;
  assign addr_last = rd_addr == ADDR_WIDTH'(BUFFER_DEPTH - 1) &&
                     bank_sel == CHAN_SEL_WIDTH'(CHANNELS - 1);
  assign readout_done = readout_valid & readout_ready & readout_last;

  assign mem.rd_addr    = rd_addr;
  assign mem.rd_advance = advance;

  // start pulse, blocked from firing twice before the FSM leaves ready
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      start_pulse <= 1'b0;
      active      <= 1'b0;
    end else begin
      start_pulse <= readout_start & (state == READY) & ~start_pulse;
      if (start_pulse) begin
        active <= 1'b1;
      end else if (step && addr_last) begin
        active <= 1'b0;
      end
    end
  end

  // bank 0 first, both counters wrap at their power-of-two size
  always_ff @(posedge adc_clk) begin
    if (adc_reset || start_pulse) begin
      rd_addr  <= '0;
      bank_sel <= '0;
    end else if (step) begin
      rd_addr <= rd_addr + 1'b1;
      if (rd_addr == ADDR_WIDTH'(BUFFER_DEPTH - 1)) begin
        bank_sel <= bank_sel + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // pipeline matched to the memory latency
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_pipe    <= '0;
      last_pipe     <= '0;
      readout_valid <= 1'b0;
      readout_last  <= 1'b0;
    end else if (advance) begin
      valid_pipe    <= {valid_pipe[READ_LATENCY-2:0], active};
      last_pipe     <= {last_pipe[READ_LATENCY-2:0], active & addr_last};
      readout_valid <= valid_pipe[READ_LATENCY-1];
      readout_last  <= last_pipe[READ_LATENCY-1];
    end
  end

  // bank select travels with its read, then picks the output word
  always_ff @(posedge adc_clk) begin
    if (advance) begin
      bank_pipe    <= {bank_pipe[READ_LATENCY-2:0], bank_sel};
      readout_data <= mem.rd_data[bank_pipe[READ_LATENCY-1]];
    end
  end

  //////////////////////////////////////////////////
  // readout FSM
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (capture_done) begin
            state <= READY;
          end
        end
        READY: begin
          if (start_pulse) begin
            state <= ACTIVE;
          end
        end
        ACTIVE: begin
          if (readout_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // a stalled beat must not change, memory pipe included
  a_hold_stable : assert property (
    @(posedge adc_clk) disable iff (adc_reset)
    readout_valid && !readout_ready |=>
      $stable(readout_data) && $stable(readout_last) && $stable(mem.rd_data)
  );

endmodule

`default_nettype wire

// File: hdl/buffer_top.sv
/*
  banked ADC sample capture buffer, top level
  - capture FSM, bank writer, sample memory, readout engine
  - one memory interface between writer, reader and ram
*/
`default_nettype none

module buffer_top
  import sample_pkg::*, memory_pkg::*;
(
  input  wire                               adc_clk,
  input  wire                               adc_reset,
  input  wire  [CHANNELS*DATA_WIDTH-1:0]    sample_data,
  input  wire  [CHANNELS-1:0]               sample_valid,
  input  wire                               hw_start,
  input  wire                               hw_stop,
  input  wire                               arm,
  input  wire  [MODE_WIDTH-1:0]             banking_mode,
  input  wire                               banking_mode_valid,
  input  wire                               capture_sw_reset,
  input  wire                               readout_start,
  input  wire                               readout_ready,
  output logic                              capture_full,
  output logic [CHANNELS*DEPTH_WIDTH-1:0]   write_depth,
  output logic                              write_depth_valid,
  output logic [DATA_WIDTH-1:0]             readout_data,
  output logic                              readout_valid,
  output logic                              readout_last
);

  logic                    capture_active;
  logic                    start_pulse;
  logic [ACTIVE_WIDTH-1:0] active_channels;
  logic                    clear;
  logic                    chain_fill;
  logic                    readout_done;

  buffer_mem_if mem_if ();

  // capture done doubles as the status strobe and the readout enable
  capture_control u_capture_control (
    .adc_clk            (adc_clk),
    .adc_reset          (adc_reset),
    .arm                (arm),
    .banking_mode       (banking_mode),
    .banking_mode_valid (banking_mode_valid),
    .capture_sw_reset   (capture_sw_reset),
    .hw_start           (hw_start),
    .hw_stop            (hw_stop),
    .capture_full       (capture_full),
    .chain_fill         (chain_fill),
    .readout_done       (readout_done),
    .capture_active     (capture_active),
    .start_pulse        (start_pulse),
    .active_channels    (active_channels),
    .clear              (clear),
    .capture_done       (write_depth_valid)
  );

  bank_writer u_bank_writer (
    .adc_clk         (adc_clk),
    .adc_reset       (adc_reset),
    .sample_data     (sample_data),
    .sample_valid    (sample_valid),
    .capture_active  (capture_active),
    .start_pulse     (start_pulse),
    .active_channels (active_channels),
    .clear           (clear),
    .capture_full    (capture_full),
    .chain_fill      (chain_fill),
    .write_depth     (write_depth),
    .mem             (mem_if.writer)
  );

  sample_memory u_sample_memory (
    .adc_clk (adc_clk),
    .mem     (mem_if.memory)
  );

  readout_engine u_readout_engine (
    .adc_clk       (adc_clk),
    .adc_reset     (adc_reset),
    .capture_done  (write_depth_valid),
    .readout_start (readout_start),
    .readout_ready (readout_ready),
    .readout_done  (readout_done),
    .readout_data  (readout_data),
    .readout_valid (readout_valid),
    .readout_last  (readout_last),
    .mem           (mem_if.reader)
  );

endmodule

`default_nettype wire

// File: sim/buffer_tb.sv
/*
  testbench for the banked ADC capture buffer
  - clock, reset and falling-edge stimulus for all banking modes
  - reference model of the bank mapping, readout checker
  - compare tasks and cycle timeout
*/
`default_nettype none

module buffer_tb
  import sample_pkg::*, memory_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TOTAL_BEATS = CHANNELS * BUFFER_DEPTH;
  // about 2000 cycles of captures and readouts, ten times that as margin
  localparam int MAX_CYCLES = 20000;

  logic                            adc_clk;
  logic                            adc_reset;
  logic [CHANNELS*DATA_WIDTH-1:0]  sample_data;
  logic [CHANNELS-1:0]             sample_valid;
  logic                            hw_start;
  logic                            hw_stop;
  logic                            arm;
  logic [MODE_WIDTH-1:0]           banking_mode;
  logic                            banking_mode_valid;
  logic                            capture_sw_reset;
  logic                            readout_start;
  logic                            readout_ready;
  logic                            capture_full;
  logic [CHANNELS*DEPTH_WIDTH-1:0] write_depth;
  logic                            write_depth_valid;
  logic [DATA_WIDTH-1:0]           readout_data;
  logic                            readout_valid;
  logic                            readout_last;

  integer seed = 32'ha05d;

  // samples accepted per channel during the current capture
  logic [DATA_WIDTH-1:0] accepted [CHANNELS][$];
  // mirror of the sample ram, plus which entries were ever written
  logic [DATA_WIDTH-1:0] exp_mem [CHANNELS][BUFFER_DEPTH];
  bit                    exp_written [CHANNELS][BUFFER_DEPTH];
  // beats of the last readout taken with ready held high
  logic [DATA_WIDTH-1:0] prev_beats [CHANNELS][BUFFER_DEPTH];

  int beat_count = 0;
  bit compare_prev = 1'b0;
  int done_count = 0;
  int cycle_count = 0;
  int saved_done;

  buffer_top uut (
    .adc_clk            (adc_clk),
    .adc_reset          (adc_reset),
    .sample_data        (sample_data),
    .sample_valid       (sample_valid),
    .hw_start           (hw_start),
    .hw_stop            (hw_stop),
    .arm                (arm),
    .banking_mode       (banking_mode),
    .banking_mode_valid (banking_mode_valid),
    .capture_sw_reset   (capture_sw_reset),
    .readout_start      (readout_start),
    .readout_ready      (readout_ready),
    .capture_full       (capture_full),
    .write_depth        (write_depth),
    .write_depth_valid  (write_depth_valid),
    .readout_data       (readout_data),
    .readout_valid      (readout_valid),
    .readout_last       (readout_last)
  );

  // 8 ns clock
  initial begin
    adc_clk = 1'b0;
    forever begin
      #4 adc_clk = ~adc_clk;
    end
  end

  //////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////

  // k-th sample of a channel, flat slot bank*depth + address
  // each full bank hands over to the bank active-count above it
  function automatic int sample_slot(input int chan, input int k, input int active);
    int bank;
    bank = chan + active * (k / BUFFER_DEPTH);
    return bank * BUFFER_DEPTH + k % BUFFER_DEPTH;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] expected, input string what);
    if (got !== expected) begin
      stop_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, expected));
    end
  endtask

  task automatic check_depth(input logic [DEPTH_WIDTH-1:0] got,
                             input logic [DEPTH_WIDTH-1:0] expected, input string what);
    if (got !== expected) begin
      stop_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, expected));
    end
  endtask

  task automatic check_bit(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      stop_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, expected));
    end
  endtask

  // move the accepted samples into the ram mirror
  task automatic commit_samples(input int active);
    int slot;
    logic [CHAN_SEL_WIDTH-1:0] bank;
    logic [ADDR_WIDTH-1:0] addr;
    for (int c = 0; c < active; c++) begin
      for (int k = 0; k < accepted[c].size(); k++) begin
        slot = sample_slot(c, k, active);
        bank = CHAN_SEL_WIDTH'(slot / BUFFER_DEPTH);
        addr = ADDR_WIDTH'(slot % BUFFER_DEPTH);
        exp_mem[bank][addr] = accepted[c][k];
        exp_written[bank][addr] = 1'b1;
      end
    end
    for (int c = 0; c < CHANNELS; c++) begin
      accepted[c].delete();
    end
  endtask

  //////////////////////////////////////////////////
  // readout checker, cycle counter
  //////////////////////////////////////////////////

  // one beat per posedge with valid and ready, bank 0 first
  always @(posedge adc_clk) begin : check_readout
    logic [CHAN_SEL_WIDTH-1:0] bank;
    logic [ADDR_WIDTH-1:0] addr;
    if (!adc_reset && readout_valid === 1'b1 && readout_ready === 1'b1) begin
      if (beat_count >= TOTAL_BEATS) begin
        stop_run("readout delivered more beats than the buffer holds");
      end else begin
        bank = CHAN_SEL_WIDTH'(beat_count / BUFFER_DEPTH);
        addr = ADDR_WIDTH'(beat_count % BUFFER_DEPTH);
        check_bit(readout_last, beat_count == TOTAL_BEATS - 1, "readout_last");
        // entries never written hold no known data
        if (exp_written[bank][addr]) begin
          // a stalled readout must repeat the beats of the ready-high pass
          if (compare_prev) begin
            check_word(readout_data, prev_beats[bank][addr],
                       $sformatf("beat %0d under back-pressure", beat_count));
          end else begin
            check_word(readout_data, exp_mem[bank][addr],
                       $sformatf("readout of bank %0d word %0d", bank, addr));
            prev_beats[bank][addr] = readout_data;
          end
        end
        beat_count = beat_count + 1;
      end
    end
  end

  always @(posedge adc_clk) begin
    cycle_count = cycle_count + 1;
    if (write_depth_valid === 1'b1) begin
      done_count = done_count + 1;
    end
    if (cycle_count >= MAX_CYCLES) begin
      stop_run($sformatf("timeout, the run did not finish within %0d clock cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks, all driven on the falling edge
  //////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  task automatic set_mode(input int mode);
    @(negedge adc_clk);
    banking_mode = MODE_WIDTH'(mode);
    banking_mode_valid = 1'b1;
    @(negedge adc_clk);
    banking_mode_valid = 1'b0;
  endtask

  task automatic pulse_arm();
    @(negedge adc_clk);
    arm = 1'b1;
    @(negedge adc_clk);
    arm = 1'b0;
  endtask

  task automatic pulse_hw_start();
    @(negedge adc_clk);
    hw_start = 1'b1;
    @(negedge adc_clk);
    hw_start = 1'b0;
  endtask

  task automatic pulse_hw_stop();
    @(negedge adc_clk);
    hw_stop = 1'b1;
    @(negedge adc_clk);
    hw_stop = 1'b0;
  endtask

  task automatic pulse_sw_reset();
    @(negedge adc_clk);
    capture_sw_reset = 1'b1;
    @(negedge adc_clk);
    capture_sw_reset = 1'b0;
  endtask

  task automatic request_readout();
    @(negedge adc_clk);
    readout_start = 1'b1;
    @(negedge adc_clk);
    readout_start = 1'b0;
  endtask

  // count valid samples on every channel at once, with random gaps
  // valid stays low for 4 cycles afterwards, clear of any trigger
  task automatic drive_samples(input int count, input int active, input bit record);
    int sent;
    bit v;
    sent = 0;
    while (sent < count) begin
      @(negedge adc_clk);
      v = ($random(seed) & 3) != 0;
      for (int c = 0; c < CHANNELS; c++) begin
        sample_data[c*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'($random(seed));
        if (v && record && c < active) begin
          accepted[c].push_back(sample_data[c*DATA_WIDTH +: DATA_WIDTH]);
        end
      end
      sample_valid = {CHANNELS{v}};
      if (v) begin
        sent++;
      end
    end
    @(negedge adc_clk);
    sample_valid = '0;
    idle_cycles(4);
  endtask

  // a full bank reads full bit set over a wrapped zero count
  task automatic check_depths(input int count, input bit full);
    logic [DEPTH_WIDTH-1:0] expected;
    expected = full ? DEPTH_WIDTH'(BUFFER_DEPTH) : DEPTH_WIDTH'(count);
    for (int b = 0; b < CHANNELS; b++) begin
      check_depth(write_depth[b*DEPTH_WIDTH +: DEPTH_WIDTH], expected,
                  $sformatf("write_depth of bank %0d", b));
    end
    check_bit(capture_full, full, "capture_full");
  endtask

  // one capture, ended by hw_stop or by the buffer filling up
  task automatic run_capture(input int mode, input int per_chan, input bit stop_early);
    int active;
    int done_before;
    active = 1 << mode;
    done_before = done_count;
    set_mode(mode);
    pulse_arm();
    idle_cycles(4);
    pulse_hw_start();
    idle_cycles(4);
    drive_samples(per_chan, active, 1'b1);
    if (stop_early) begin
      pulse_hw_stop();
    end
    // a fill ends the capture while the trailing idle cycles still run
    while (done_count == done_before) begin
      @(negedge adc_clk);
    end
    check_depths(per_chan, !stop_early);
    commit_samples(active);
  endtask

  task automatic run_readout(input bit random_ready);
    beat_count = 0;
    compare_prev = random_ready;
    request_readout();
    while (beat_count < TOTAL_BEATS) begin
      @(negedge adc_clk);
      readout_ready = random_ready ? 1'($random(seed)) : 1'b1;
    end
    readout_ready = 1'b1;
    idle_cycles(8);
    check_bit(readout_valid, 1'b0, "readout_valid after the last beat");
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    adc_reset = 1'b1;
    sample_data = '0;
    sample_valid = '0;
    hw_start = 1'b0;
    hw_stop = 1'b0;
    arm = 1'b0;
    banking_mode = '0;
    banking_mode_valid = 1'b0;
    capture_sw_reset = 1'b0;
    readout_start = 1'b0;
    readout_ready = 1'b1;
    exp_written = '{default: 1'b0};
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    adc_reset = 1'b0;

    check_bit(capture_full, 1'b0, "capture_full after reset");
    check_bit(write_depth_valid, 1'b0, "write_depth_valid after reset");
    check_bit(readout_valid, 1'b0, "readout_valid after reset");
    check_bit(readout_last, 1'b0, "readout_last after reset");

    // readout request with nothing captured yet
    request_readout();
    repeat (16) begin
      @(negedge adc_clk);
      check_bit(readout_valid, 1'b0, "readout_valid without a capture");
    end

    // mode 0, channel 0 chained through all banks
    run_capture(0, TOTAL_BEATS, 1'b0);
    run_readout(1'b0);

    // empty capture, ram keeps its data, random back-pressure
    run_capture(0, 0, 1'b1);
    run_readout(1'b1);

    // mode 1, channel c into bank c then bank c+2
    run_capture(1, 2 * BUFFER_DEPTH, 1'b0);
    run_readout(1'b0);

    // mode 2, early stop, then arm and start while on hold
    run_capture(2, 5, 1'b1);
    saved_done = done_count;
    pulse_arm();
    idle_cycles(2);
    pulse_hw_start();
    idle_cycles(4);
    drive_samples(6, CHANNELS, 1'b0);
    if (done_count != saved_done) begin
      stop_run("write_depth_valid pulsed while the capture was on hold");
    end
    check_depths(5, 1'b0);
    run_readout(1'b0);

    // software reset in the middle of a save
    pulse_arm();
    idle_cycles(4);
    pulse_hw_start();
    idle_cycles(4);
    drive_samples(3, CHANNELS, 1'b1);
    saved_done = done_count;
    pulse_sw_reset();
    idle_cycles(12);
    if (done_count != saved_done) begin
      stop_run("write_depth_valid pulsed after a capture software reset");
    end
    commit_samples(CHANNELS);

    // next capture restarts at address 0
    run_capture(2, 9, 1'b1);
    run_readout(1'b0);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/sample_pkg.sv
hdl/memory_pkg.sv
hdl/buffer_mem_if.sv
hdl/capture_control.sv
hdl/bank_writer.sv
hdl/sample_memory.sv
hdl/readout_engine.sv
hdl/buffer_top.sv
sim/buffer_tb.sv

// File: Makefile
# Verilator lint, simulation and cleanup for the ADC capture buffer

TB_TOP  = buffer_tb
RTL_TOP = buffer_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 -f files.f --top-module $(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
